/* include/ooo_settings.svh */
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

// Datapath and register file
`define OOO_XLEN 32
`define OOO_NREGS 32
`define OOO_REG_AW 5

// Tags, 0 is reserved for "no producer"
`define OOO_TAG_W 6
`define OOO_TAG_ALU 1
`define OOO_TAG_MUL 2

// Internal op code width and station latencies
`define OOO_OP_W 3
`define OOO_ALU_CYCLES 1
`define OOO_MUL_CYCLES 4

`endif

/* rtl/isa_pkg.sv */
package isa_pkg;

	// One instruction word, seen as R-type or as I-type
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm12;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
	} instr_word_u;

	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_OR  = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	localparam logic [6:0] F7_BASE   = 7'b0000000;
	localparam logic [6:0] F7_SUB    = 7'b0100000;
	localparam logic [6:0] F7_MULDIV = 7'b0000001;

endpackage

/* rtl/ooo_pkg.sv */
package ooo_pkg;
`include "ooo_settings.svh"

	localparam logic [`OOO_OP_W-1:0] ALUOP_ADD = 3'd0;
	localparam logic [`OOO_OP_W-1:0] ALUOP_SUB = 3'd1;
	localparam logic [`OOO_OP_W-1:0] ALUOP_AND = 3'd2;
	localparam logic [`OOO_OP_W-1:0] ALUOP_OR  = 3'd3;
	localparam logic [`OOO_OP_W-1:0] ALUOP_XOR = 3'd4;
	localparam logic [`OOO_OP_W-1:0] ALUOP_MUL = 3'd5;

	function automatic logic [`OOO_XLEN-1:0] execute(
		input logic [`OOO_OP_W-1:0] op,
		input logic [`OOO_XLEN-1:0] a,
		input logic [`OOO_XLEN-1:0] b
	);
		case (op)
			ALUOP_ADD: return a + b;
			ALUOP_SUB: return a - b;
			ALUOP_AND: return a & b;
			ALUOP_OR:  return a | b;
			ALUOP_XOR: return a ^ b;
			// Low half of the product, as RV32M MUL
			ALUOP_MUL: return a * b;
			default:   return '0;
		endcase
	endfunction

	// Bus carries the result of the given producer
	function automatic logic tag_hit(
		input logic                  valid,
		input logic [`OOO_TAG_W-1:0] bus_tag,
		input logic [`OOO_TAG_W-1:0] tag
	);
		return valid && (tag != '0) && (bus_tag == tag);
	endfunction

endpackage

/* rtl/reg_status_table.sv */
`timescale 1ns/1ps
`include "ooo_settings.svh"

module reg_status_table (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [`OOO_REG_AW-1:0] rs1_addr,
	input  logic [`OOO_REG_AW-1:0] rs2_addr,
	output logic [`OOO_TAG_W-1:0]  rs1_tag,
	output logic [`OOO_TAG_W-1:0]  rs2_tag,
	output logic                   rs1_ready,
	output logic                   rs2_ready,
	input  logic                   disp_en,
	input  logic [`OOO_REG_AW-1:0] disp_addr,
	input  logic [`OOO_TAG_W-1:0]  disp_tag,
	input  logic                   cdb_valid,
	input  logic [`OOO_TAG_W-1:0]  cdb_tag,
	output logic [`OOO_NREGS-1:0]  rf_wen
);
	import ooo_pkg::*;

	localparam int AW = `OOO_REG_AW;

	logic                  ready_q [`OOO_NREGS];
	logic [`OOO_TAG_W-1:0] tag_q   [`OOO_NREGS];
	logic [`OOO_NREGS-1:0] bus_hit;
	logic [`OOO_NREGS-1:0] disp_hit;

	// Bus clears busy entries unless dispatch renames the same register
	always_comb begin
		for (int i = 0; i < `OOO_NREGS; i++) begin
			bus_hit[i]  = !ready_q[i] && tag_hit(cdb_valid, cdb_tag, tag_q[i]);
			disp_hit[i] = disp_en && (disp_addr == AW'(i)) && (i != 0);
			rf_wen[i]   = bus_hit[i] && !disp_hit[i];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `OOO_NREGS; i++) begin
				ready_q[i] <= 1'b1;
				tag_q[i]   <= '0;
			end
		end else begin
			for (int i = 0; i < `OOO_NREGS; i++) begin
				if (disp_hit[i]) begin
					ready_q[i] <= 1'b0;
					tag_q[i]   <= disp_tag;
				end else if (bus_hit[i]) begin
					ready_q[i] <= 1'b1;
					tag_q[i]   <= '0;
				end
			end
		end
	end

	// x0 has no producer
	assign rs1_ready = (rs1_addr == '0) || ready_q[rs1_addr];
	assign rs2_ready = (rs2_addr == '0) || ready_q[rs2_addr];
	assign rs1_tag   = tag_q[rs1_addr];
	assign rs2_tag   = tag_q[rs2_addr];

endmodule

/* rtl/reg_file.sv */
`timescale 1ns/1ps
`include "ooo_settings.svh"

module reg_file (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [`OOO_REG_AW-1:0] rd1_addr,
	input  logic [`OOO_REG_AW-1:0] rd2_addr,
	input  logic [`OOO_REG_AW-1:0] dbg_addr,
	output logic [`OOO_XLEN-1:0]   rd1_data,
	output logic [`OOO_XLEN-1:0]   rd2_data,
	output logic [`OOO_XLEN-1:0]   dbg_data,
	input  logic [`OOO_NREGS-1:0]  wen,
	input  logic [`OOO_XLEN-1:0]   wdata
);

	logic [`OOO_XLEN-1:0] regs [`OOO_NREGS];

	// Broadcast value lands in every register flagged by the mask
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `OOO_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 1; i < `OOO_NREGS; i++) begin
				if (wen[i]) begin
					regs[i] <= wdata;
				end
			end
		end
	end

	assign rd1_data = (rd1_addr == '0) ? '0 : regs[rd1_addr];
	assign rd2_data = (rd2_addr == '0) ? '0 : regs[rd2_addr];
	assign dbg_data = (dbg_addr == '0) ? '0 : regs[dbg_addr];

endmodule

/* rtl/reservation_station.sv */
`timescale 1ns/1ps
`include "ooo_settings.svh"

module reservation_station #(
	parameter int TAG     = 1,
	parameter int LATENCY = 1
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  issue,
	input  logic [`OOO_OP_W-1:0]  op,
	input  logic [`OOO_XLEN-1:0]  a_val,
	input  logic [`OOO_XLEN-1:0]  b_val,
	input  logic [`OOO_TAG_W-1:0] a_tag,
	input  logic [`OOO_TAG_W-1:0] b_tag,
	output logic                  busy,
	input  logic                  cdb_valid,
	input  logic [`OOO_TAG_W-1:0] cdb_tag,
	input  logic [`OOO_XLEN-1:0]  cdb_data,
	output logic                  req,
	input  logic                  ack,
	output logic [`OOO_TAG_W-1:0] res_tag,
	output logic [`OOO_XLEN-1:0]  res_data
);
	import ooo_pkg::*;

	localparam int CNT_W = (LATENCY > 1) ? $clog2(LATENCY) : 1;
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(LATENCY - 1);

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_EXEC = 2'd1;
	localparam logic [1:0] S_REQ  = 2'd2;
	localparam logic [1:0] S_REL  = 2'd3;

	logic [1:0]            state;
	logic [CNT_W-1:0]      cnt;
	logic [`OOO_OP_W-1:0]  op_q;
	logic [`OOO_XLEN-1:0]  a_q;
	logic [`OOO_XLEN-1:0]  b_q;
	logic [`OOO_TAG_W-1:0] a_tag_q;
	logic [`OOO_TAG_W-1:0] b_tag_q;
	logic                  operands_ready;
	logic                  a_hit;
	logic                  b_hit;
	logic                  done;

	assign operands_ready = (a_tag_q == '0) && (b_tag_q == '0);
	assign a_hit = tag_hit(cdb_valid, cdb_tag, a_tag_q);
	assign b_hit = tag_hit(cdb_valid, cdb_tag, b_tag_q);
	// Last execute cycle
	assign done = (state == S_EXEC) && operands_ready && (cnt == LAST_CNT);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= S_IDLE;
			cnt     <= '0;
			a_tag_q <= '0;
			b_tag_q <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (issue) begin
						a_tag_q <= a_tag;
						b_tag_q <= b_tag;
						cnt     <= '0;
						state   <= S_EXEC;
					end
				end
				S_EXEC: begin
					if (a_hit) begin
						a_tag_q <= '0;
					end
					if (b_hit) begin
						b_tag_q <= '0;
					end
					if (done) begin
						state <= S_REQ;
					end else if (operands_ready) begin
						cnt <= cnt + 1'b1;
					end
				end
				// Hold the result until the arbiter takes it
				S_REQ: begin
					if (ack) begin
						state <= S_REL;
					end
				end
				default: begin
					if (!ack) begin
						state <= S_IDLE;
					end
				end
			endcase
		end
	end

	// Operands and result
	always_ff @(posedge clk) begin
		if (issue && state == S_IDLE) begin
			op_q <= op;
			a_q  <= a_val;
			b_q  <= b_val;
		end else begin
			if (a_hit) begin
				a_q <= cdb_data;
			end
			if (b_hit) begin
				b_q <= cdb_data;
			end
		end
		if (done) begin
			res_data <= execute(op_q, a_q, b_q);
		end
	end

	assign busy    = (state != S_IDLE);
	assign req     = (state == S_REQ);
	assign res_tag = TAG[`OOO_TAG_W-1:0];

endmodule

/* rtl/cdb_arbiter.sv */
`timescale 1ns/1ps
`include "ooo_settings.svh"

module cdb_arbiter (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  req_alu,
	input  logic                  req_mul,
	output logic                  ack_alu,
	output logic                  ack_mul,
	input  logic [`OOO_TAG_W-1:0] tag_alu,
	input  logic [`OOO_XLEN-1:0]  data_alu,
	input  logic [`OOO_TAG_W-1:0] tag_mul,
	input  logic [`OOO_XLEN-1:0]  data_mul,
	output logic                  cdb_valid,
	output logic [`OOO_TAG_W-1:0] cdb_tag,
	output logic [`OOO_XLEN-1:0]  cdb_data
);

	logic granting;
	logic last_mul;
	logic pick_mul;
	logic start;
	logic released;

	// Round robin, the loser of the last contest wins a tie
	assign pick_mul = req_mul && (!req_alu || !last_mul);
	assign start    = !granting && (req_alu || req_mul);
	assign released = (ack_alu && !req_alu) || (ack_mul && !req_mul);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			granting  <= 1'b0;
			last_mul  <= 1'b0;
			ack_alu   <= 1'b0;
			ack_mul   <= 1'b0;
			cdb_valid <= 1'b0;
			cdb_tag   <= '0;
		end else begin
			cdb_valid <= 1'b0;
			if (start) begin
				granting  <= 1'b1;
				last_mul  <= pick_mul;
				ack_mul   <= pick_mul;
				ack_alu   <= !pick_mul;
				cdb_valid <= 1'b1;
				cdb_tag   <= pick_mul ? tag_mul : tag_alu;
			end else if (granting && released) begin
				granting <= 1'b0;
				ack_alu  <= 1'b0;
				ack_mul  <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			cdb_data <= pick_mul ? data_mul : data_alu;
		end
	end

endmodule

/* rtl/dispatch_unit.sv */
`timescale 1ns/1ps
`include "ooo_settings.svh"

module dispatch_unit (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   instr_req,
	output logic                   instr_ack,
	input  isa_pkg::instr_word_u   instr_word,
	output logic [`OOO_REG_AW-1:0] rs1_addr,
	output logic [`OOO_REG_AW-1:0] rs2_addr,
	input  logic [`OOO_TAG_W-1:0]  rs1_tag,
	input  logic [`OOO_TAG_W-1:0]  rs2_tag,
	input  logic                   rs1_ready,
	input  logic                   rs2_ready,
	input  logic [`OOO_XLEN-1:0]   rd1_data,
	input  logic [`OOO_XLEN-1:0]   rd2_data,
	input  logic                   cdb_valid,
	input  logic [`OOO_TAG_W-1:0]  cdb_tag,
	input  logic [`OOO_XLEN-1:0]   cdb_data,
	input  logic                   alu_busy,
	input  logic                   mul_busy,
	output logic                   issue_alu,
	output logic                   issue_mul,
	output logic [`OOO_OP_W-1:0]   op,
	output logic [`OOO_XLEN-1:0]   a_val,
	output logic [`OOO_XLEN-1:0]   b_val,
	output logic [`OOO_TAG_W-1:0]  a_tag,
	output logic [`OOO_TAG_W-1:0]  b_tag,
	output logic                   disp_en,
	output logic [`OOO_REG_AW-1:0] disp_addr,
	output logic [`OOO_TAG_W-1:0]  disp_tag
);
	import isa_pkg::*;
	import ooo_pkg::*;

	localparam logic [`OOO_TAG_W-1:0] ALU_TAG = `OOO_TAG_ALU;
	localparam logic [`OOO_TAG_W-1:0] MUL_TAG = `OOO_TAG_MUL;

	logic                 holding;
	logic                 legal;
	logic                 is_mul;
	logic                 is_imm;
	logic                 go;
	logic [`OOO_XLEN-1:0] imm_ext;

	always_comb begin
		legal  = 1'b0;
		is_mul = 1'b0;
		is_imm = 1'b0;
		op     = ALUOP_ADD;
		if (instr_word.r.opcode == OPC_OP) begin
			legal = 1'b1;
			case ({instr_word.r.funct7, instr_word.r.funct3})
				{F7_BASE, F3_ADD}: op = ALUOP_ADD;
				{F7_SUB, F3_ADD}:  op = ALUOP_SUB;
				{F7_BASE, F3_AND}: op = ALUOP_AND;
				{F7_BASE, F3_OR}:  op = ALUOP_OR;
				{F7_BASE, F3_XOR}: op = ALUOP_XOR;
				// MUL shares funct3 000 with ADD
				{F7_MULDIV, F3_ADD}: begin
					op     = ALUOP_MUL;
					is_mul = 1'b1;
				end
				default: legal = 1'b0;
			endcase
		end else if (instr_word.i.opcode == OPC_OP_IMM && instr_word.i.funct3 == F3_ADD) begin
			legal  = 1'b1;
			is_imm = 1'b1;
		end
	end

	assign rs1_addr = instr_word.r.rs1;
	assign rs2_addr = instr_word.r.rs2;
	assign imm_ext  = {{(`OOO_XLEN - 12){instr_word.i.imm12[11]}}, instr_word.i.imm12};

	// Pending sources take the bus value when it arrives this very cycle
	always_comb begin
		a_val = rd1_data;
		a_tag = '0;
		if (!rs1_ready) begin
			if (tag_hit(cdb_valid, cdb_tag, rs1_tag)) begin
				a_val = cdb_data;
			end else begin
				a_tag = rs1_tag;
			end
		end
		b_val = rd2_data;
		b_tag = '0;
		if (is_imm) begin
			b_val = imm_ext;
		end else if (!rs2_ready) begin
			if (tag_hit(cdb_valid, cdb_tag, rs2_tag)) begin
				b_val = cdb_data;
			end else begin
				b_tag = rs2_tag;
			end
		end
	end

	// Unsupported words are acknowledged without waiting on a station
	assign go        = !holding && instr_req && (!legal || !(is_mul ? mul_busy : alu_busy));
	assign instr_ack = go || holding;
	assign issue_alu = go && legal && !is_mul;
	assign issue_mul = go && legal && is_mul;
	assign disp_en   = go && legal && (instr_word.r.rd != '0);
	assign disp_addr = instr_word.r.rd;
	assign disp_tag  = is_mul ? MUL_TAG : ALU_TAG;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			holding <= 1'b0;
		end else if (go) begin
			holding <= 1'b1;
		end else if (holding && !instr_req) begin
			holding <= 1'b0;
		end
	end

endmodule

/* rtl/ooo_core.sv */
`timescale 1ns/1ps
`include "ooo_settings.svh"

module ooo_core (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   instr_req,
	output logic                   instr_ack,
	input  isa_pkg::instr_word_u   instr_word,
	input  logic [`OOO_REG_AW-1:0] dbg_addr,
	output logic [`OOO_XLEN-1:0]   dbg_data,
	output logic                   cdb_valid,
	output logic [`OOO_TAG_W-1:0]  cdb_tag,
	output logic [`OOO_XLEN-1:0]   cdb_data,
	output logic                   idle
);

	logic [`OOO_REG_AW-1:0] rs1_addr;
	logic [`OOO_REG_AW-1:0] rs2_addr;
	logic [`OOO_TAG_W-1:0]  rs1_tag;
	logic [`OOO_TAG_W-1:0]  rs2_tag;
	logic                   rs1_ready;
	logic                   rs2_ready;
	logic [`OOO_XLEN-1:0]   rd1_data;
	logic [`OOO_XLEN-1:0]   rd2_data;
	logic                   disp_en;
	logic [`OOO_REG_AW-1:0] disp_addr;
	logic [`OOO_TAG_W-1:0]  disp_tag;
	logic [`OOO_NREGS-1:0]  rf_wen;
	logic                   issue_alu;
	logic                   issue_mul;
	logic [`OOO_OP_W-1:0]   op;
	logic [`OOO_XLEN-1:0]   a_val;
	logic [`OOO_XLEN-1:0]   b_val;
	logic [`OOO_TAG_W-1:0]  a_tag;
	logic [`OOO_TAG_W-1:0]  b_tag;
	logic                   alu_busy;
	logic                   mul_busy;
	logic                   req_alu;
	logic                   req_mul;
	logic                   ack_alu;
	logic                   ack_mul;
	logic [`OOO_TAG_W-1:0]  tag_alu;
	logic [`OOO_TAG_W-1:0]  tag_mul;
	logic [`OOO_XLEN-1:0]   data_alu;
	logic [`OOO_XLEN-1:0]   data_mul;

	dispatch_unit u_dispatch (
		.clk, .rst_n, .instr_req, .instr_ack, .instr_word,
		.rs1_addr, .rs2_addr, .rs1_tag, .rs2_tag, .rs1_ready, .rs2_ready,
		.rd1_data, .rd2_data, .cdb_valid, .cdb_tag, .cdb_data,
		.alu_busy, .mul_busy, .issue_alu, .issue_mul,
		.op, .a_val, .b_val, .a_tag, .b_tag, .disp_en, .disp_addr, .disp_tag
	);

	reg_status_table u_rst (
		.clk, .rst_n, .rs1_addr, .rs2_addr, .rs1_tag, .rs2_tag, .rs1_ready, .rs2_ready,
		.disp_en, .disp_addr, .disp_tag, .cdb_valid, .cdb_tag, .rf_wen
	);

	// Operand reads share the table's source addresses
	reg_file u_rf (
		.clk, .rst_n, .rd1_addr(rs1_addr), .rd2_addr(rs2_addr), .dbg_addr,
		.rd1_data, .rd2_data, .dbg_data, .wen(rf_wen), .wdata(cdb_data)
	);

	reservation_station #(.TAG(`OOO_TAG_ALU), .LATENCY(`OOO_ALU_CYCLES)) u_rs_alu (
		.clk, .rst_n, .issue(issue_alu), .op, .a_val, .b_val, .a_tag, .b_tag,
		.busy(alu_busy), .cdb_valid, .cdb_tag, .cdb_data,
		.req(req_alu), .ack(ack_alu), .res_tag(tag_alu), .res_data(data_alu)
	);

	reservation_station #(.TAG(`OOO_TAG_MUL), .LATENCY(`OOO_MUL_CYCLES)) u_rs_mul (
		.clk, .rst_n, .issue(issue_mul), .op, .a_val, .b_val, .a_tag, .b_tag,
		.busy(mul_busy), .cdb_valid, .cdb_tag, .cdb_data,
		.req(req_mul), .ack(ack_mul), .res_tag(tag_mul), .res_data(data_mul)
	);

	cdb_arbiter u_arb (
		.clk, .rst_n, .req_alu, .req_mul, .ack_alu, .ack_mul,
		.tag_alu, .data_alu, .tag_mul, .data_mul, .cdb_valid, .cdb_tag, .cdb_data
	);

	assign idle = !(alu_busy || mul_busy);

endmodule

/* verification/ooo_core_assertions.sv */
`timescale 1ns/1ps

module ooo_core_assertions #(
	parameter bit TWO_PAIRS = 1'b1
) (
	input logic clk,
	input logic rst_n,
	input logic req_a,
	input logic ack_a,
	input logic req_b,
	input logic ack_b,
	input logic bus_valid
);

	int fail_count = 0;

	ack_a_after_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(ack_a) |-> req_a)
	else begin
		fail_count++;
		$error("ack rose on port a with no request pending");
	end

	bus_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		bus_valid |=> !bus_valid)
	else begin
		fail_count++;
		$error("bus valid held for more than one cycle");
	end

	req_held_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
		req_a && !ack_a |=> req_a)
	else begin
		fail_count++;
		$error("request dropped before its ack");
	end

	// Second pair and grant exclusivity exist only where both requesters meet
	if (TWO_PAIRS) begin : g_pair_b
		ack_b_after_req: assert property (@(posedge clk) disable iff (!rst_n)
			$rose(ack_b) |-> req_b)
		else begin
			fail_count++;
			$error("ack rose on port b with no request pending");
		end

		// One grant at a time
		acks_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
			!(ack_a && ack_b))
		else begin
			fail_count++;
			$error("both acks high in the same cycle");
		end
	end

endmodule

bind cdb_arbiter ooo_core_assertions arb_checks (
	.clk, .rst_n, .req_a(req_alu), .ack_a(ack_alu), .req_b(req_mul), .ack_b(ack_mul),
	.bus_valid(cdb_valid)
);

// Station side sees only its own request pair
bind reservation_station ooo_core_assertions #(.TWO_PAIRS(1'b0)) station_checks (
	.clk, .rst_n, .req_a(req), .ack_a(ack), .req_b(1'b0), .ack_b(1'b0),
	.bus_valid(cdb_valid)
);

/* verification/ooo_core_tb.sv */
`timescale 1ns/1ps
`include "ooo_settings.svh"

module ooo_core_tb;
	import isa_pkg::*;
	import ooo_pkg::*;

	// About 60 instructions, none near 50 cycles, plus room for drains and reads
	localparam int MAX_INSTR      = 70;
	localparam int TIMEOUT_CYCLES = MAX_INSTR * 50 + 500;
	localparam logic [2:0] RANDOM_OPS [6] = '{ALUOP_ADD, ALUOP_SUB, ALUOP_AND,
		ALUOP_OR, ALUOP_XOR, ALUOP_MUL};

	logic                   clk;
	logic                   rst_n;
	logic                   instr_req;
	logic                   instr_ack;
	instr_word_u            instr_word;
	logic [`OOO_REG_AW-1:0] dbg_addr;
	logic [`OOO_XLEN-1:0]   dbg_data;
	logic                   cdb_valid;
	logic [`OOO_TAG_W-1:0]  cdb_tag;
	logic [`OOO_XLEN-1:0]   cdb_data;
	logic                   idle;

	logic [`OOO_XLEN-1:0]   model [`OOO_NREGS];
	logic [`OOO_TAG_W-1:0]  bus_log [$];
	logic [`OOO_XLEN-1:0]   bus_data_log [$];
	logic [31:0]            seed;
	int                     cycles;
	int                     errors;
	int                     checks;
	int                     tests;
	int                     failed_tests;
	int                     test_start_errors;
	int                     assert_errors;

	ooo_core DUT (
		.clk, .rst_n, .instr_req, .instr_ack, .instr_word, .dbg_addr, .dbg_data,
		.cdb_valid, .cdb_tag, .cdb_data, .idle
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("** FAIL **");
			$finish;
		end
	end

	// Broadcasts, sampled mid-cycle
	always @(negedge clk) begin
		if (rst_n && cdb_valid) begin
			bus_log.push_back(cdb_tag);
			bus_data_log.push_back(cdb_data);
		end
	end

	function automatic logic [31:0] next_random();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic [31:0] reg_word(input logic [2:0] op, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2);
		instr_word_u w;
		w.r.opcode = OPC_OP;
		w.r.rd     = rd;
		w.r.rs1    = rs1;
		w.r.rs2    = rs2;
		w.r.funct3 = F3_ADD;
		w.r.funct7 = F7_BASE;
		case (op)
			ALUOP_SUB: w.r.funct7 = F7_SUB;
			ALUOP_AND: w.r.funct3 = F3_AND;
			ALUOP_OR:  w.r.funct3 = F3_OR;
			ALUOP_XOR: w.r.funct3 = F3_XOR;
			ALUOP_MUL: w.r.funct7 = F7_MULDIV;
			default:   w.r.funct7 = F7_BASE;
		endcase
		return w;
	endfunction

	function automatic logic [31:0] imm_word(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [4:0] rd);
		instr_word_u w;
		w.i.opcode = OPC_OP_IMM;
		w.i.funct3 = F3_ADD;
		w.i.rd     = rd;
		w.i.rs1    = rs1;
		w.i.imm12  = imm;
		return w;
	endfunction

	// Four-phase handshake on the instruction port
	task automatic send_instr(input logic [31:0] word);
		@(posedge clk);
		#1;
		instr_word = word;
		instr_req  = 1'b1;
		do begin
			@(negedge clk);
		end while (!instr_ack);
		@(posedge clk);
		#1;
		instr_req = 1'b0;
		do begin
			@(negedge clk);
		end while (instr_ack);
	endtask

	task automatic drain();
		do begin
			@(negedge clk);
		end while (!idle);
	endtask

	task automatic read_reg(input logic [4:0] addr, output logic [31:0] data);
		@(posedge clk);
		#1;
		dbg_addr = addr;
		@(negedge clk);
		data = dbg_data;
	endtask

	task automatic check(input logic [31:0] got, input logic [31:0] expected, input string what);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("[FAIL] %0t ns: %s: got %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic verify_reg(input logic [4:0] r);
		logic [31:0] value;
		read_reg(r, value);
		check(value, model[r], $sformatf("register x%0d", r));
	endtask

	// Sequential model first, in program order
	task automatic reg_op(input logic [2:0] op, input logic [4:0] rd, input logic [4:0] rs1,
		input logic [4:0] rs2);
		if (rd != 5'd0) begin
			model[rd] = execute(op, model[rs1], model[rs2]);
		end
		send_instr(reg_word(op, rd, rs1, rs2));
	endtask

	task automatic add_imm(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		if (rd != 5'd0) begin
			model[rd] = execute(ALUOP_ADD, model[rs1], {{20{imm[11]}}, imm});
		end
		send_instr(imm_word(imm, rs1, rd));
	endtask

	task automatic report_test(input string name);
		tests++;
		if (errors == test_start_errors) begin
			$display("Test %0d, %s: passed", tests, name);
		end else begin
			failed_tests++;
			$display("Test %0d, %s: failed with %0d errors", tests, name,
				errors - test_start_errors);
		end
		test_start_errors = errors;
	endtask

	task automatic independent_ops();
		add_imm(5'd1, 5'd0, 12'd100);
		add_imm(5'd2, 5'd0, 12'hff9);
		reg_op(ALUOP_ADD, 5'd3, 5'd1, 5'd2);
		reg_op(ALUOP_SUB, 5'd4, 5'd1, 5'd2);
		reg_op(ALUOP_AND, 5'd5, 5'd1, 5'd2);
		reg_op(ALUOP_OR, 5'd6, 5'd1, 5'd2);
		reg_op(ALUOP_XOR, 5'd7, 5'd1, 5'd2);
		drain();
		for (int r = 1; r <= 7; r++) begin
			verify_reg(5'(r));
		end
		report_test("independent ALU ops");
	endtask

	// The dependent ADD must wait for the multiply broadcast
	task automatic mul_dependency();
		add_imm(5'd8, 5'd0, 12'd12);
		add_imm(5'd9, 5'd0, 12'hffd);
		drain();
		bus_log.delete();
		bus_data_log.delete();
		reg_op(ALUOP_MUL, 5'd10, 5'd8, 5'd9);
		reg_op(ALUOP_ADD, 5'd11, 5'd10, 5'd8);
		drain();
		check(32'(bus_log.size()), 32'd2, "broadcast count");
		if (bus_log.size() == 2) begin
			check(32'(bus_log[0]), `OOO_TAG_MUL, "first broadcast tag");
			check(32'(bus_log[1]), `OOO_TAG_ALU, "second broadcast tag");
			check(bus_data_log[0], model[10], "first broadcast data");
			check(bus_data_log[1], model[11], "second broadcast data");
		end
		verify_reg(5'd10);
		verify_reg(5'd11);
		report_test("MUL with dependent ADD");
	endtask

	task automatic bus_sharing();
		int alu_seen;
		int mul_seen;
		alu_seen = 0;
		mul_seen = 0;
		bus_log.delete();
		bus_data_log.delete();
		reg_op(ALUOP_MUL, 5'd12, 5'd8, 5'd8);
		reg_op(ALUOP_ADD, 5'd13, 5'd9, 5'd9);
		drain();
		foreach (bus_log[k]) begin
			if (bus_log[k] == `OOO_TAG_ALU) begin
				alu_seen++;
				check(bus_data_log[k], model[13], "ALU broadcast data");
			end
			if (bus_log[k] == `OOO_TAG_MUL) begin
				mul_seen++;
				check(bus_data_log[k], model[12], "MUL broadcast data");
			end
		end
		check(32'(bus_log.size()), 32'd2, "broadcast count");
		check(32'(alu_seen), 32'd1, "ALU broadcasts");
		check(32'(mul_seen), 32'd1, "MUL broadcasts");
		verify_reg(5'd12);
		verify_reg(5'd13);
		report_test("shared bus");
	endtask

	// Last grant went to MUL, so the ADDI takes the bus tie and the MUL broadcasts last
	task automatic newer_write_wins();
		reg_op(ALUOP_MUL, 5'd17, 5'd9, 5'd9);
		drain();
		bus_log.delete();
		bus_data_log.delete();
		reg_op(ALUOP_MUL, 5'd14, 5'd8, 5'd9);
		add_imm(5'd14, 5'd0, 12'd55);
		drain();
		check(32'(bus_log.size()), 32'd2, "broadcast count");
		if (bus_log.size() == 2) begin
			check(32'(bus_log[0]), `OOO_TAG_ALU, "first broadcast tag");
			check(32'(bus_log[1]), `OOO_TAG_MUL, "second broadcast tag");
		end
		verify_reg(5'd14);
		verify_reg(5'd17);
		report_test("newer write wins");
	endtask

	task automatic x0_handling();
		add_imm(5'd0, 5'd0, 12'd77);
		reg_op(ALUOP_ADD, 5'd0, 5'd1, 5'd2);
		reg_op(ALUOP_MUL, 5'd0, 5'd8, 5'd9);
		reg_op(ALUOP_OR, 5'd15, 5'd0, 5'd1);
		reg_op(ALUOP_ADD, 5'd16, 5'd0, 5'd0);
		drain();
		verify_reg(5'd0);
		verify_reg(5'd15);
		verify_reg(5'd16);
		report_test("register x0");
	endtask

	task automatic random_sequence();
		logic [31:0] rnd;
		int          sel;
		for (int n = 0; n < 40; n++) begin
			rnd = next_random();
			sel = int'(rnd[31:28]) % 7;
			if (sel == 6) begin
				add_imm(rnd[4:0], rnd[9:5], rnd[21:10]);
			end else begin
				reg_op(RANDOM_OPS[sel], rnd[4:0], rnd[9:5], rnd[14:10]);
			end
		end
		drain();
		for (int r = 0; r < `OOO_NREGS; r++) begin
			verify_reg(5'(r));
		end
		report_test("random sequence");
	endtask

	initial begin
		seed              = 32'h7885_6548;
		rst_n             = 1'b0;
		instr_req         = 1'b0;
		instr_word        = '0;
		dbg_addr          = '0;
		cycles            = 0;
		errors            = 0;
		checks            = 0;
		tests             = 0;
		failed_tests      = 0;
		test_start_errors = 0;
		for (int r = 0; r < `OOO_NREGS; r++) begin
			model[r] = '0;
		end
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		independent_ops();
		mul_dependency();
		bus_sharing();
		newer_write_wins();
		x0_handling();
		random_sequence();
		assert_errors = DUT.u_arb.arb_checks.fail_count
			+ DUT.u_rs_alu.station_checks.fail_count
			+ DUT.u_rs_mul.station_checks.fail_count;
		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
			tests, failed_tests, checks, errors, assert_errors);
		if (errors == 0 && failed_tests == 0 && assert_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

/* list.f */
+incdir+include
rtl/isa_pkg.sv
rtl/ooo_pkg.sv
rtl/reg_status_table.sv
rtl/reg_file.sv
rtl/reservation_station.sv
rtl/cdb_arbiter.sv
rtl/dispatch_unit.sv
rtl/ooo_core.sv
verification/ooo_core_assertions.sv
verification/ooo_core_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module ooo_core_tb -o sim_ooo_core

./obj_dir/sim_ooo_core +verilator+error+limit+100 > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -qF '** FAIL **' sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"
